//--- Makefile
VERILATOR  ?= verilator
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0
TOP        := icache_tb
FILELIST   := vlog.f
OBJ_DIR    := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/icache_checker.sv
`timescale 1ns/1ps

module icache_checker
    import icache_pkg::*;
    import mem_bus_pkg::*;
(
    input logic         clk,
    input logic         rst_n,
    input logic         req_valid,
    input fetch_req_t   req,
    input logic         req_ready,
    input logic         resp_valid,
    input fetch_resp_t  resp,
    input logic         refill_req_valid,
    input refill_req_t  refill_req,
    input logic         refill_rdy,
    input logic         beat_valid,
    input refill_beat_t beat,
    input logic         beat_ready
);

    // one accepted fetch waiting for its response
    typedef struct packed {
        logic [31:0]             pc;
        logic [cookie_width-1:0] cookie;
        logic                    hit;         // model prediction
        logic [31:0]             accept_cyc;
    } fetch_exp_t;

    fetch_exp_t          exp_q [$];
    logic [tag_bits-1:0] m_tag [num_sets][num_ways];
    way_vec_t            m_valid [num_sets];
    int                  order [num_sets][num_ways];  // way numbers, most recent first

    int          cyc = 0;
    int          outstanding = 0;
    int          errors = 0;
    int          answered = 0;
    int          hits = 0;
    int          misses = 0;
    int          mark_errors = 0;
    int          mark_answered = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    logic        req_active = 1'b0;      // refill request seen, not yet taken
    logic        miss_requested = 1'b0;  // head fetch already sent its refill
    logic [31:0] held_addr = '0;
    int          last_beat_cyc = 0;

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] want);
        errors++;
        $display("Fail at %0t: %s got %0h expected %0h", $time, name, got, want);
    endtask

    task automatic report_problem(input string msg);
        errors++;
        $display("Error at %0t: %s", $time, msg);
    endtask

    task automatic reset_model();
        for (int s = 0; s < num_sets; s++) begin
            m_valid[s] = '0;
            for (int w = 0; w < num_ways; w++) begin
                order[s][w] = w;  // way 3 is the first victim
            end
        end
        exp_q.delete();
        outstanding    = 0;
        req_active     = 1'b0;
        miss_requested = 1'b0;
    endtask

    // true LRU over an ordered list, a miss replaces the last entry
    task automatic model_access(input logic [31:0] pc, output logic was_hit);
        int                  idx;
        int                  way;
        int                  pos;
        logic [tag_bits-1:0] tag;
        idx = int'(pc[offset_bits +: index_bits]);
        tag = pc[31 -: tag_bits];
        way = -1;
        pos = 0;
        for (int w = 0; w < num_ways; w++) begin
            if (m_valid[idx][w] && m_tag[idx][w] == tag) way = w;
        end
        was_hit = (way >= 0);
        if (!was_hit) begin
            way                  = order[idx][num_ways-1];
            m_tag[idx][way]      = tag;
            m_valid[idx][way]    = 1'b1;
        end
        for (int i = 0; i < num_ways; i++) begin
            if (order[idx][i] == way) pos = i;
        end
        for (int i = pos; i > 0; i--) begin
            order[idx][i] = order[idx][i-1];
        end
        order[idx][0] = way;
    endtask

    task automatic check_response();
        fetch_exp_t  e;
        logic [31:0] waddr;
        logic [63:0] exp_data;
        if (exp_q.size() == 0) begin
            report_problem("response arrived with no fetch outstanding");
        end else begin
            e = exp_q.pop_front();
            outstanding--;
            answered++;
            waddr    = {2'b00, e.pc[31:3], 1'b0};  // first word of the doubleword
            exp_data = {icache_tb.scramble(waddr + 32'd1), icache_tb.scramble(waddr)};
            if (resp.data !== exp_data) report_mismatch("resp.data", resp.data, exp_data);
            if (resp.pc !== e.pc) report_mismatch("resp.pc", {32'd0, resp.pc}, {32'd0, e.pc});
            if (resp.cookie !== e.cookie) begin
                report_mismatch("resp.cookie", {32'd0, resp.cookie}, {32'd0, e.cookie});
            end
            if (e.hit) begin
                if (cyc != int'(e.accept_cyc) + 1) begin
                    report_mismatch("resp_valid cycle", 64'(cyc), 64'(int'(e.accept_cyc) + 1));
                end
            end else if (!miss_requested) begin
                report_problem("miss answered without any refill request");
            end else if (cyc != last_beat_cyc + 2) begin
                report_mismatch("resp_valid cycle", 64'(cyc), 64'(last_beat_cyc + 2));
            end
            miss_requested = 1'b0;
        end
    endtask

    task automatic check_refill_port();
        if (req_active) begin
            if (!refill_req_valid) begin
                report_problem("refill request dropped before memory took it");
            end else if (refill_req !== held_addr) begin
                report_mismatch("refill_req", {32'd0, refill_req}, {32'd0, held_addr});
            end
            if (!refill_req_valid || refill_rdy) req_active = 1'b0;
        end else if (refill_req_valid) begin
            if (exp_q.size() == 0) begin
                report_problem("refill request with no fetch outstanding");
            end else if (exp_q[0].hit) begin
                report_problem("refill request for a fetch the model counts as a hit");
            end else if (miss_requested) begin
                report_problem("second refill request for the same miss");
            end else if (refill_req !== {exp_q[0].pc[31:offset_bits], 5'd0}) begin
                report_mismatch("refill_req", {32'd0, refill_req},
                                {32'd0, exp_q[0].pc[31:offset_bits], 5'd0});
            end
            miss_requested = 1'b1;
            held_addr      = refill_req;
            req_active     = !refill_rdy;
        end
        if (beat_valid && beat_ready && beat.last) last_beat_cyc = cyc;
    endtask

    task automatic record_accept();
        fetch_exp_t e;
        logic       h;
        model_access(req.pc, h);
        e.pc         = req.pc;
        e.cookie     = req.cookie;
        e.hit        = h;
        e.accept_cyc = cyc;
        exp_q.push_back(e);
        outstanding++;
        if (h) hits++;
        else misses++;
    endtask

    // sampled on the rising edge, inputs were driven half a cycle earlier
    always @(posedge clk) begin
        if (!rst_n) begin
            reset_model();
        end else begin
            if (resp_valid) check_response();
            check_refill_port();
            if (req_valid && req_ready) record_accept();
        end
        cyc = cyc + 1;
    end

    task automatic check_idle_outputs();
        if (req_ready !== 1'b1) report_mismatch("req_ready", 64'(req_ready), 64'd1);
        if (resp_valid !== 1'b0) report_mismatch("resp_valid", 64'(resp_valid), 64'd0);
        if (refill_req_valid !== 1'b0) begin
            report_mismatch("refill_req_valid", 64'(refill_req_valid), 64'd0);
        end
        if (beat_ready !== 1'b0) report_mismatch("beat_ready", 64'(beat_ready), 64'd0);
    endtask

    task automatic report_test(input string name);
        int errs;
        errs = errors - mark_errors;
        tests_run++;
        if (errs != 0) tests_failed++;
        $display("test %s: %0d responses, %0d errors, %s", name, answered - mark_answered,
                 errs, (errs == 0) ? "pass" : "fail");
        mark_errors   = errors;
        mark_answered = answered;
    endtask

    task automatic report_totals();
        $display("%0d tests, %0d passed, %0d failed, %0d errors (%0d hits, %0d misses)",
                 tests_run, tests_run - tests_failed, tests_failed, errors, hits, misses);
    endtask

endmodule

//--- bench/icache_tb.sv
`timescale 1ns/1ps

module icache_tb
    import icache_pkg::*;
    import mem_bus_pkg::*;
();

    localparam int num_fetches    = 400;
    localparam int timeout_cycles = num_fetches * 60;  // worst-case miss for every fetch
    localparam int seed           = 85537;

    logic         clk;
    logic         rst_n;
    logic         req_valid;
    fetch_req_t   req;
    logic         req_ready;
    logic         resp_valid;
    fetch_resp_t  resp;
    logic         refill_req_valid;
    refill_req_t  refill_req;
    logic         refill_rdy;
    logic         beat_valid;
    refill_beat_t beat;
    logic         beat_ready;
    int           cycles = 0;

    icache dut (.*);

    icache_checker chk (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("timeout after %0d cycles, %0d fetches still unanswered",
                     cycles, chk.outstanding);
            $display("TEST FAILED");
            $finish;
        end
    end

    // memory contents, one word per word address
    function automatic logic [31:0] scramble(input logic [31:0] word_addr);
        logic [31:0] x;
        x = word_addr * 32'h9e37_79b1;
        x = x ^ (x >> 15) ^ {word_addr[15:0], word_addr[31:16]};
        return x;
    endfunction

    function automatic logic [31:0] make_pc(input logic [tag_bits-1:0] tag,
                                            input logic [index_bits-1:0] idx,
                                            input logic [2:0] word);
        return {tag, idx, word, 2'b00};
    endfunction

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic send_fetch(input logic [31:0] pc);
        if ($urandom_range(0, 7) == 0) @(negedge clk);  // occasional bubble
        req_valid  = 1'b1;
        req.pc     = {pc[31:2], 2'b00};
        req.cookie = $urandom;
        while (!req_ready) @(negedge clk);
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic wait_drained();
        while (chk.outstanding != 0) @(negedge clk);
    endtask

    // eight neighbouring lines, so only the first touches miss
    task automatic run_hit_phase(input int n);
        logic [tag_bits-1:0]   tag;
        logic [index_bits-1:0] first;
        tag   = tag_bits'($urandom);
        first = index_bits'($urandom);
        for (int i = 0; i < n; i++) begin
            send_fetch(make_pc(tag, first + index_bits'($urandom_range(0, 7)),
                               3'($urandom)));
        end
    endtask

    // five tags per set, one more than the ways
    task automatic run_conflict_phase(input int sets, input int per_set);
        logic [tag_bits-1:0]   base;
        logic [index_bits-1:0] idx;
        int                    t;
        for (int s = 0; s < sets; s++) begin
            base = tag_bits'($urandom);
            idx  = index_bits'($urandom);
            for (int i = 0; i < per_set; i++) begin
                t = (i < 5) ? i : int'($urandom_range(0, 4));
                send_fetch(make_pc(base ^ tag_bits'(t << 12), idx, 3'($urandom)));
            end
        end
    endtask

    task automatic run_random_phase(input int n);
        logic [31:0] pc;
        for (int i = 0; i < n; i++) begin
            if ($urandom_range(0, 1) == 0) pc = $urandom;
            else pc = 32'h0004_0000 + {18'd0, 12'($urandom), 2'b00};  // twice the cache size
            send_fetch(pc);
        end
    endtask

    // memory side: random grant delay and gaps between beats
    initial begin : memory
        logic [31:0] word_base;
        forever begin
            @(negedge clk);
            if (rst_n && refill_req_valid) begin
                word_base = {2'b00, refill_req[31:2]};
                repeat ($urandom_range(0, 5)) @(negedge clk);
                refill_rdy = 1'b1;
                @(negedge clk);
                refill_rdy = 1'b0;
                for (int b = 0; b < beats_per_line; b++) begin
                    repeat ($urandom_range(0, 3)) @(negedge clk);
                    beat_valid = 1'b1;
                    beat.data  = scramble(word_base + 32'(b));
                    beat.last  = (b == beats_per_line - 1);
                    while (!beat_ready) @(negedge clk);
                    @(negedge clk);
                    beat_valid = 1'b0;
                end
            end
        end
    end

    initial begin
        void'($urandom(seed));
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        refill_rdy = 1'b0;
        beat_valid = 1'b0;
        beat       = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        chk.check_idle_outputs();
        chk.report_test("reset");
        run_hit_phase(120);
        wait_drained();
        chk.report_test("hits");
        run_conflict_phase(4, 35);
        wait_drained();
        chk.report_test("conflict");
        run_random_phase(140);
        wait_drained();
        chk.report_test("random");
        chk.report_totals();
        if (chk.errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- src/icache.sv
`timescale 1ns/1ps

module icache
    import icache_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    // fetch port
    input  logic         req_valid,
    input  fetch_req_t   req,
    output logic         req_ready,
    output logic         resp_valid,
    output fetch_resp_t  resp,
    // refill port
    output logic         refill_req_valid,
    output refill_req_t  refill_req,
    input  logic         refill_rdy,
    input  logic         beat_valid,
    input  refill_beat_t beat,
    output logic         beat_ready
);

    fetch_req_t           req_q;  // accepted fetch
    logic                 req_load;
    logic                 hit;
    way_vec_t             hit_way;
    way_vec_t             victim;
    way_vec_t             fill_way;
    way_vec_t             wr_way;
    way_vec_t             lru_way;
    logic                 fill_we;
    logic                 lru_upd;
    logic                 use_refill;
    logic                 fill_done;
    line_t [num_ways-1:0] rd_lines;
    line_t                refill_line;
    line_t                hit_line;
    line_t                sel_line;

    logic [index_bits-1:0] rd_index;
    logic [index_bits-1:0] q_index;
    logic [tag_bits-1:0]   rd_tag;
    logic [tag_bits-1:0]   q_tag;

    // arrays look up the incoming pc, writes use the held one
    assign rd_index = req.pc[offset_bits +: index_bits];
    assign rd_tag   = req.pc[31 -: tag_bits];
    assign q_index  = req_q.pc[offset_bits +: index_bits];
    assign q_tag    = req_q.pc[31 -: tag_bits];

    always_ff @(posedge clk) begin
        if (req_load) req_q <= req;
    end

    assign wr_way  = fill_we ? fill_way : '0;
    assign lru_way = fill_we ? fill_way : hit_way;  // fill and hit never coincide

    assign refill_req = refill_req_t'({req_q.pc[31:offset_bits], {offset_bits{1'b0}}});

    icache_tagv u_tagv (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_index (rd_index),
        .rd_tag   (rd_tag),
        .wr_index (q_index),
        .wr_tag   (q_tag),
        .wr_way   (wr_way),
        .hit_way  (hit_way),
        .hit      (hit)
    );

    icache_data u_data (
        .clk      (clk),
        .rd_index (rd_index),
        .wr_index (q_index),
        .wr_way   (wr_way),
        .wr_line  (refill_line),
        .rd_lines (rd_lines)
    );

    icache_lru u_lru (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_index  (rd_index),
        .upd_index (q_index),
        .upd_valid (lru_upd),
        .upd_way   (lru_way),
        .victim    (victim)
    );

    icache_refill_buf u_refill_buf (
        .clk        (clk),
        .rst_n      (rst_n),
        .beat_valid (beat_valid),
        .beat       (beat),
        .capture    (beat_ready),
        .line       (refill_line),
        .done       (fill_done)
    );

    icache_ctrl u_ctrl (
        .clk              (clk),
        .rst_n            (rst_n),
        .req_valid        (req_valid),
        .hit              (hit),
        .victim           (victim),
        .refill_rdy       (refill_rdy),
        .fill_done        (fill_done),
        .req_ready        (req_ready),
        .req_load         (req_load),
        .refill_req_valid (refill_req_valid),
        .beat_ready       (beat_ready),
        .fill_way         (fill_way),
        .fill_we          (fill_we),
        .lru_upd          (lru_upd),
        .use_refill       (use_refill),
        .resp_valid       (resp_valid)
    );

    // and-or mux over the one-hot hit vector
    always_comb begin
        hit_line = '0;
        for (int w = 0; w < num_ways; w++) begin
            hit_line |= rd_lines[w] & {line_bits{hit_way[w]}};
        end
    end

    assign sel_line = use_refill ? refill_line : hit_line;

    // pc[4:3] picks the doubleword within the line
    assign resp.data   = sel_line[req_q.pc[4:3]*dword_bits +: dword_bits];
    assign resp.pc     = req_q.pc;
    assign resp.cookie = req_q.cookie;

endmodule

//--- src/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl
    import icache_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     req_valid,
    input  logic     hit,         // registered lookup result
    input  way_vec_t victim,      // lru choice for the looked-up set
    input  logic     refill_rdy,
    input  logic     fill_done,
    output logic     req_ready,
    output logic     req_load,
    output logic     refill_req_valid,
    output logic     beat_ready,
    output way_vec_t fill_way,
    output logic     fill_we,
    output logic     lru_upd,
    output logic     use_refill,  // answer from the refill line
    output logic     resp_valid
);

    typedef enum logic [2:0] {
        idle,
        lookup,
        request,
        refill,
        reply
    } state_t;

    state_t state;
    state_t state_nxt;

    logic lookup_hit;
    logic lookup_miss;

    assign lookup_hit  = (state == lookup) && hit;
    assign lookup_miss = (state == lookup) && !hit;

    // a hit keeps the port open so fetches stream back to back
    assign req_ready = (state == idle) || lookup_hit;
    assign req_load  = req_valid && req_ready;

    assign refill_req_valid = lookup_miss || (state == request);
    assign beat_ready       = (state == refill);

    // line is complete in the buffer while done is high
    assign fill_we    = (state == refill) && fill_done;
    assign lru_upd    = lookup_hit || fill_we;
    assign use_refill = (state == reply);
    assign resp_valid = lookup_hit || (state == reply);

    always_comb begin
        state_nxt = state;
        case (state)
            idle: begin
                if (req_load) state_nxt = lookup;
            end
            lookup: begin
                if (hit) state_nxt = req_load ? lookup : idle;
                else if (refill_rdy) state_nxt = refill;  // taken at once
                else state_nxt = request;
            end
            request: begin
                if (refill_rdy) state_nxt = refill;
            end
            refill: begin
                if (fill_done) state_nxt = reply;
            end
            reply: begin
                state_nxt = idle;
            end
            default: begin
                state_nxt = idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            state <= state_nxt;
        end
    end

    // victim is only meaningful during the lookup, keep it for the fill
    always_ff @(posedge clk) begin
        if (lookup_miss) begin
            fill_way <= victim;
        end
    end

    // refill request is held until memory takes it
    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        refill_req_valid && !refill_rdy |=> refill_req_valid);

endmodule

//--- src/icache_data.sv
`timescale 1ns/1ps

module icache_data
    import icache_pkg::*;
(
    input  logic                  clk,
    input  logic [index_bits-1:0] rd_index,
    input  logic [index_bits-1:0] wr_index,
    input  way_vec_t              wr_way,    // selects the way to fill
    input  line_t                 wr_line,
    output line_t [num_ways-1:0]  rd_lines   // all ways of the set, one cycle later
);

    // one storage bank per way
    for (genvar w = 0; w < num_ways; w++) begin : g_way
        line_t mem [num_sets];

        always_ff @(posedge clk) begin
            if (wr_way[w]) begin
                mem[wr_index] <= wr_line;  // whole line at once
            end
            rd_lines[w] <= mem[rd_index];
        end
    end

endmodule

//--- src/icache_lru.sv
`timescale 1ns/1ps

module icache_lru
    import icache_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [index_bits-1:0] rd_index,
    input  logic [index_bits-1:0] upd_index,
    input  logic                  upd_valid,
    input  way_vec_t              upd_way,
    output way_vec_t              victim
);

    typedef logic [num_ways-1:0][1:0] age_set_t;  // age 0 is most recent

    age_set_t ages [num_sets];
    age_set_t upd_set;
    age_set_t rd_set;
    way_vec_t oldest;

    // move touched way to the front, age those that were younger
    function automatic age_set_t touch(age_set_t cur, way_vec_t way);
        age_set_t   nxt;
        logic [1:0] hit_age;
        hit_age = 2'd0;
        for (int w = 0; w < num_ways; w++) begin
            if (way[w]) hit_age = cur[w];
        end
        for (int w = 0; w < num_ways; w++) begin
            if (way[w]) nxt[w] = 2'd0;
            else if (cur[w] < hit_age) nxt[w] = cur[w] + 2'd1;
            else nxt[w] = cur[w];
        end
        return nxt;
    endfunction

    function automatic logic is_perm(age_set_t a);
        logic [num_ways-1:0] seen;
        seen = '0;
        for (int w = 0; w < num_ways; w++) begin
            seen[a[w]] = 1'b1;
        end
        return &seen;
    endfunction

    assign upd_set = touch(ages[upd_index], upd_way);
    // forward an update landing on the set being read in the same cycle
    assign rd_set = (upd_valid && upd_index == rd_index) ? upd_set : ages[rd_index];

    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            oldest[w] = (rd_set[w] == 2'd3);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < num_sets; s++) begin
                for (int w = 0; w < num_ways; w++) begin
                    ages[s][w] <= 2'(w);  // way 0 youngest, way 3 first victim
                end
            end
            victim <= '0;
        end else begin
            if (upd_valid) ages[upd_index] <= upd_set;
            victim <= oldest;
        end
    end

    a_age_perm: assert property (@(posedge clk) disable iff (!rst_n)
        upd_valid |=> is_perm(ages[$past(upd_index)]));

endmodule

//--- src/icache_pkg.sv
package icache_pkg;

    // cache geometry
    localparam int num_ways   = 4;
    localparam int num_sets   = 64;
    localparam int line_bytes = 32;

    // pc field split
    localparam int offset_bits = $clog2(line_bytes);           // 5
    localparam int index_bits  = $clog2(num_sets);             // 6
    localparam int tag_bits    = 32 - index_bits - offset_bits; // 21

    localparam int cookie_width = 32;

    localparam int line_bits  = line_bytes * 8;
    localparam int dword_bits = 64;

    // request as seen on the fetch port, also held in the request register
    typedef struct packed {
        logic [cookie_width-1:0] cookie;
        logic [31:0]             pc;
    } fetch_req_t;

    // response back to the CPU
    typedef struct packed {
        logic [dword_bits-1:0]   data;
        logic [31:0]             pc;
        logic [cookie_width-1:0] cookie;
    } fetch_resp_t;

    // one bit per way, one-hot or zero
    typedef logic [num_ways-1:0] way_vec_t;

    typedef logic [line_bits-1:0] line_t;

endpackage

//--- src/icache_refill_buf.sv
`timescale 1ns/1ps

module icache_refill_buf
    import icache_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  logic         beat_valid,
    input  refill_beat_t beat,
    input  logic         capture,  // beat_ready from the controller
    output line_t        line,
    output logic         done
);

    localparam int cnt_bits = $clog2(beats_per_line);

    logic [cnt_bits-1:0] beat_cnt;
    logic                take;

    assign take = beat_valid && capture;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            beat_cnt <= '0;
            done     <= 1'b0;
        end else begin
            done <= take && beat.last;  // one cycle after the last beat
            if (take) begin
                beat_cnt <= beat.last ? '0 : beat_cnt + 1'b1;
            end
        end
    end

    // beat n lands in word n of the line
    always_ff @(posedge clk) begin
        if (take) begin
            line[beat_cnt*beat_bits +: beat_bits] <= beat.data;
        end
    end

    // memory marks last on the eighth beat and on no other
    a_last_on_eighth: assert property (@(posedge clk) disable iff (!rst_n)
        take |-> (beat.last == (beat_cnt == cnt_bits'(beats_per_line - 1))));

endmodule

//--- src/icache_tagv.sv
`timescale 1ns/1ps

module icache_tagv
    import icache_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [index_bits-1:0] rd_index,
    input  logic [tag_bits-1:0]   rd_tag,
    input  logic [index_bits-1:0] wr_index,
    input  logic [tag_bits-1:0]   wr_tag,
    input  way_vec_t              wr_way,   // zero means no write
    output way_vec_t              hit_way,
    output logic                  hit
);

    logic [tag_bits-1:0] tags [num_sets][num_ways];
    way_vec_t            valid [num_sets];
    way_vec_t            match;

    // compare all ways of the addressed set
    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            match[w] = valid[rd_index][w] && (tags[rd_index][w] == rd_tag);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hit_way <= '0;
            hit     <= 1'b0;
        end else begin
            hit_way <= match;
            hit     <= |match;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < num_sets; s++) begin
                valid[s] <= '0;
            end
        end else begin
            for (int w = 0; w < num_ways; w++) begin
                if (wr_way[w]) valid[wr_index][w] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < num_ways; w++) begin
            if (wr_way[w]) tags[wr_index][w] <= wr_tag;
        end
    end

    // a line lives in at most one way, so the registered hit is never ambiguous
    a_hit_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(hit_way));

endmodule

//--- src/mem_bus_pkg.sv
package mem_bus_pkg;

    // refill port shape
    localparam int beat_bits      = 32;
    localparam int beats_per_line = 8;

    // one returned beat, last marks the end of a line
    typedef struct packed {
        logic [beat_bits-1:0] data;
        logic                 last;
    } refill_beat_t;

    // line-aligned byte address of the requested line
    typedef logic [31:0] refill_req_t;

endpackage

//--- vlog.f
src/icache_pkg.sv
src/mem_bus_pkg.sv
src/icache_tagv.sv
src/icache_data.sv
src/icache_lru.sv
src/icache_refill_buf.sv
src/icache_ctrl.sv
src/icache.sv
bench/icache_checker.sv
bench/icache_tb.sv
